/* decode_pkg.sv */
// **************************************************
// Decode package
// Shared widths, prefix byte values, segment codes
// and opcode classes for the IA-32 decode stage
// **************************************************

package decode_pkg;

  // Fetch window and pointer widths
  localparam int WINDOW_BYTES = 16;
  localparam int EIP_W        = 32;

  // Instruction length, up to 15 bytes
  localparam int LEN_W        = 4;

  // Prefix bytes recognised at the head of the window
  localparam logic [7:0] PFX_REPNE  = 8'hF2;
  localparam logic [7:0] PFX_CS     = 8'h2E;
  localparam logic [7:0] PFX_SS     = 8'h36;
  localparam logic [7:0] PFX_DS     = 8'h3E;
  localparam logic [7:0] PFX_ES     = 8'h26;
  localparam logic [7:0] PFX_FS     = 8'h64;
  localparam logic [7:0] PFX_GS     = 8'h65;
  localparam logic [7:0] PFX_OPSIZE = 8'h66;
  localparam logic [7:0] PFX_0F     = 8'h0F;

  // Segment register encoding, DS is the default data segment
  typedef enum logic [2:0] {
    ES = 3'd0,
    CS = 3'd1,
    SS = 3'd2,
    DS = 3'd3,
    FS = 3'd4,
    GS = 3'd5
  } seg_t;

  // Coarse class of the decoded opcode
  typedef enum logic [2:0] {
    OP_NOP     = 3'd0,
    OP_ALU     = 3'd1,
    OP_MOV     = 3'd2,
    OP_BRANCH  = 3'd3,
    OP_HLT     = 3'd4,
    OP_IRET    = 3'd5,
    OP_INVALID = 3'd6
  } op_class_t;

endpackage

/* prefix_scan.sv */
// **************************************************
// Prefix scan
// Counts the run of leading prefix bytes and flags
// repne, operand size and segment override
// **************************************************

`timescale 1ns/1ns

module prefix_scan import decode_pkg::*; #(
  parameter int MAX_PREFIX = 4
) (
  input  logic [WINDOW_BYTES*8-1:0] fetch_bytes,
  output logic [2:0]                pfx_count,
  output logic                      size_over,
  output logic                      repne,
  output logic                      seg_over_pr,
  output seg_t                      seg_over
);

  logic [MAX_PREFIX-1:0] is_pfx;
  logic [MAX_PREFIX-1:0] in_run;

  // Match each candidate slot against the nine prefix values
  always_comb begin
    for (int i = 0; i < MAX_PREFIX; i++) begin
      case (fetch_bytes[i*8 +: 8])
        PFX_REPNE, PFX_CS, PFX_SS, PFX_DS, PFX_ES,
        PFX_FS, PFX_GS, PFX_OPSIZE, PFX_0F: is_pfx[i] = 1'b1;
        default:                            is_pfx[i] = 1'b0;
      endcase
    end
  end

  // Thermometer mask, a gap ends the run
  always_comb begin
    in_run[0] = is_pfx[0];
    for (int i = 1; i < MAX_PREFIX; i++) begin
      in_run[i] = in_run[i-1] & is_pfx[i];
    end
  end

  // Later slots overwrite earlier ones so the last segment prefix wins
  always_comb begin
    pfx_count   = '0;
    size_over   = 1'b0;
    repne       = 1'b0;
    seg_over_pr = 1'b0;
    seg_over    = DS;
    for (int i = 0; i < MAX_PREFIX; i++) begin
      if (in_run[i]) begin
        pfx_count = pfx_count + 3'd1;
        case (fetch_bytes[i*8 +: 8])
          PFX_REPNE:  repne = 1'b1;
          PFX_OPSIZE: size_over = 1'b1;
          PFX_CS: begin
            seg_over_pr = 1'b1;
            seg_over    = CS;
          end
          PFX_SS: begin
            seg_over_pr = 1'b1;
            seg_over    = SS;
          end
          PFX_DS: begin
            seg_over_pr = 1'b1;
            seg_over    = DS;
          end
          PFX_ES: begin
            seg_over_pr = 1'b1;
            seg_over    = ES;
          end
          PFX_FS: begin
            seg_over_pr = 1'b1;
            seg_over    = FS;
          end
          PFX_GS: begin
            seg_over_pr = 1'b1;
            seg_over    = GS;
          end
          default: ;
        endcase
      end
    end
  end

  // Opcode select downstream only covers MAX_PREFIX + 1 positions
  a_pfx_count_max: assert property (@(fetch_bytes)
    $isunknown(pfx_count) || pfx_count <= MAX_PREFIX);

endmodule

/* opcode_table.sv */
// **************************************************
// Opcode table
// Classifies the opcode byte and reports ModRM
// presence and immediate size
// **************************************************

`timescale 1ns/1ns

module opcode_table import decode_pkg::*; (
  input  logic [7:0] opcode,
  input  logic       size_over,
  output op_class_t  op_class,
  output logic       modrm_pr,
  output logic [2:0] imm_bytes
);

  logic [2:0] imm_full;

  // Full-size immediate shrinks to a word under 66
  assign imm_full = size_over ? 3'd2 : 3'd4;

  always_comb begin
    op_class  = OP_INVALID;
    modrm_pr  = 1'b0;
    imm_bytes = 3'd0;
    case (opcode) inside
      8'h90: op_class = OP_NOP;
      8'hF4: op_class = OP_HLT;
      8'hCF: op_class = OP_IRET;
      8'h01: begin
        op_class = OP_ALU;
        modrm_pr = 1'b1;
      end
      8'h81: begin
        op_class  = OP_ALU;
        modrm_pr  = 1'b1;
        imm_bytes = imm_full;
      end
      8'h83: begin
        op_class  = OP_ALU;
        modrm_pr  = 1'b1;
        imm_bytes = 3'd1;
      end
      8'h89, 8'h8B: begin
        op_class = OP_MOV;
        modrm_pr = 1'b1;
      end
      // mov r32, imm with the register in the low bits
      [8'hB8:8'hBF]: begin
        op_class  = OP_MOV;
        imm_bytes = imm_full;
      end
      8'hE8: begin
        op_class  = OP_BRANCH;
        imm_bytes = imm_full;
      end
      8'hEB: begin
        op_class  = OP_BRANCH;
        imm_bytes = 3'd1;
      end
      default: ;
    endcase
  end

endmodule

/* modrm_decode.sv */
// **************************************************
// ModRM decode
// Byte count, SIB presence and displacement size
// for 32-bit addressing forms
// **************************************************

`timescale 1ns/1ns

module modrm_decode (
  input  logic [7:0] modrm,
  input  logic [2:0] sib_base,
  output logic [2:0] modrm_bytes,
  output logic       sib_pr,
  output logic [2:0] disp_bytes
);

  logic [1:0] mod_f;
  logic [2:0] rm_f;

  assign mod_f = modrm[7:6];
  assign rm_f  = modrm[2:0];

  // r/m of 100 escapes to SIB in any memory form
  assign sib_pr = (mod_f != 2'b11) && (rm_f == 3'b100);

  always_comb begin
    case (mod_f)
      2'b00: begin
        // disp32 only, or SIB without a base register
        if (rm_f == 3'b101) begin
          disp_bytes = 3'd4;
        end else if (sib_pr && sib_base == 3'b101) begin
          disp_bytes = 3'd4;
        end else begin
          disp_bytes = 3'd0;
        end
      end
      2'b01:   disp_bytes = 3'd1;
      2'b10:   disp_bytes = 3'd4;
      default: disp_bytes = 3'd0;
    endcase
  end

  // ModRM itself, then SIB, then displacement
  assign modrm_bytes = 3'd1 + {2'b00, sib_pr} + disp_bytes;

endmodule

/* field_extract.sv */
// **************************************************
// Field extract
// Pulls opcode, ModRM, SIB, displacement and
// immediate out of the window, forms length and EIP
// **************************************************

`timescale 1ns/1ns

module field_extract import decode_pkg::*; #(
  parameter int MAX_PREFIX = 4
) (
  input  logic [WINDOW_BYTES*8-1:0] fetch_bytes,
  input  logic [EIP_W-1:0]          fetch_eip,
  input  logic [2:0]                pfx_count,
  input  logic                      size_over,
  input  op_class_t                 op_class,
  input  logic                      modrm_pr,
  input  logic [2:0]                imm_bytes,
  input  logic [2:0]                modrm_bytes,
  input  logic                      sib_pr,
  input  logic [2:0]                disp_bytes,
  output logic [7:0]                opcode,
  output logic [7:0]                modrm,
  output logic [2:0]                sib_base,
  output logic [1:0]                scale,
  output logic [31:0]               disp32,
  output logic [31:0]               imm32,
  output logic [LEN_W-1:0]          len,
  output logic [EIP_W-1:0]          eip_next
);

  localparam int SUM_W = LEN_W + 1;

  logic [WINDOW_BYTES*8-1:0] body;
  logic [7:0]                sib;
  logic                      valid_op;
  logic                      use_modrm;
  logic [3:0]                disp_off;
  logic [3:0]                imm_off;
  logic [31:0]               disp_raw;
  logic [31:0]               imm_raw;
  logic [SUM_W-1:0]          len_full;

  // Window realigned so the opcode sits in byte 0
  always_comb begin
    body = fetch_bytes;
    for (int k = 0; k <= MAX_PREFIX; k++) begin
      if (pfx_count == k) begin
        body = fetch_bytes >> (8 * k);
      end
    end
  end

  assign opcode   = body[7:0];
  assign modrm    = body[15:8];
  assign sib      = body[23:16];
  assign sib_base = sib[2:0];

  // An unknown opcode takes no ModRM or immediate
  assign valid_op  = (op_class != OP_INVALID);
  assign use_modrm = modrm_pr && valid_op;

  assign disp_off = 4'd2 + {3'b000, sib_pr};
  assign imm_off  = 4'd1 + (use_modrm ? {1'b0, modrm_bytes} : 4'd0);
  assign disp_raw = body[{disp_off, 3'b000} +: 32];
  assign imm_raw  = body[{imm_off, 3'b000} +: 32];

  assign scale = (use_modrm && sib_pr) ? sib[7:6] : 2'b00;

  always_comb begin
    disp32 = '0;
    if (use_modrm) begin
      case (disp_bytes)
        3'd1:    disp32 = {{24{disp_raw[7]}}, disp_raw[7:0]};
        3'd4:    disp32 = disp_raw;
        default: disp32 = '0;
      endcase
    end
  end

  always_comb begin
    if (!valid_op || imm_bytes == 3'd0) begin
      imm32 = '0;
    end else if (imm_bytes == 3'd1) begin
      imm32 = {{24{imm_raw[7]}}, imm_raw[7:0]};
    end else if (size_over) begin
      imm32 = {16'h0000, imm_raw[15:0]};
    end else begin
      imm32 = imm_raw;
    end
  end

  // One bit wider so an overlong form is visible
  assign len_full = SUM_W'(pfx_count) + SUM_W'(1)
                  + (use_modrm ? SUM_W'(modrm_bytes) : SUM_W'(0))
                  + (valid_op ? SUM_W'(imm_bytes) : SUM_W'(0));

  assign len      = len_full[LEN_W-1:0];
  assign eip_next = fetch_eip + EIP_W'(len);

  // Prefix, table and ModRM sizes together stay within the IA-32 limit
  a_len_range: assert property (@(fetch_bytes)
    $isunknown(len_full) || (len_full >= 1 && len_full <= 15));

endmodule

/* decode_latch.sv */
// **************************************************
// Decode latch
// Output register stage with the valid strobe and
// final data segment choice
// **************************************************

`timescale 1ns/1ns

module decode_latch import decode_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             fetch_valid,
  input  logic [EIP_W-1:0] eip_curr,
  input  logic [EIP_W-1:0] eip_next,
  input  logic [LEN_W-1:0] len,
  input  op_class_t        op_class,
  input  logic [7:0]       opcode,
  input  logic             modrm_pr,
  input  logic             sib_pr,
  input  logic [1:0]       scale,
  input  logic [31:0]      disp32,
  input  logic [31:0]      imm32,
  input  logic             size_over,
  input  logic             seg_over_pr,
  input  seg_t             seg_over,
  input  logic             repne,
  output logic             de_valid,
  output logic [EIP_W-1:0] de_eip_curr,
  output logic [EIP_W-1:0] de_eip_next,
  output logic [LEN_W-1:0] de_len,
  output op_class_t        de_op_class,
  output logic [7:0]       de_opcode,
  output logic             de_modrm_pr,
  output logic             de_sib_pr,
  output logic [1:0]       de_scale,
  output logic [31:0]      de_disp32,
  output logic [31:0]      de_imm32,
  output seg_t             de_seg,
  output logic             de_size_over,
  output logic             de_repne
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_valid     <= 1'b0;
      de_eip_curr  <= '0;
      de_eip_next  <= '0;
      de_len       <= '0;
      de_op_class  <= op_class_t'(3'd0);
      de_opcode    <= '0;
      de_modrm_pr  <= 1'b0;
      de_sib_pr    <= 1'b0;
      de_scale     <= '0;
      de_disp32    <= '0;
      de_imm32     <= '0;
      de_seg       <= seg_t'(3'd0);
      de_size_over <= 1'b0;
      de_repne     <= 1'b0;
    end else begin
      de_valid <= fetch_valid;
      // Fields hold between strobes
      if (fetch_valid) begin
        de_eip_curr  <= eip_curr;
        de_eip_next  <= eip_next;
        de_len       <= len;
        de_op_class  <= op_class;
        de_opcode    <= opcode;
        de_modrm_pr  <= modrm_pr;
        de_sib_pr    <= sib_pr & modrm_pr;
        de_scale     <= scale;
        de_disp32    <= disp32;
        de_imm32     <= imm32;
        de_seg       <= seg_over_pr ? seg_over : DS;
        de_size_over <= size_over;
        de_repne     <= repne;
      end
    end
  end

  // Every strobed instruction carries at least its opcode byte
  a_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    de_valid |-> de_len != '0);

endmodule

/* decode_stage.sv */
// **************************************************
// Decode stage
// IA-32 instruction decode, prefix scan through
// field extraction into one output register stage
// **************************************************

`timescale 1ns/1ns

module decode_stage import decode_pkg::*; #(
  parameter int MAX_PREFIX = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_valid,
  input  logic [EIP_W-1:0]          fetch_eip,
  input  logic [WINDOW_BYTES*8-1:0] fetch_bytes,
  output logic                      de_valid,
  output logic [EIP_W-1:0]          de_eip_curr,
  output logic [EIP_W-1:0]          de_eip_next,
  output logic [LEN_W-1:0]          de_len,
  output op_class_t                 de_op_class,
  output logic [7:0]                de_opcode,
  output logic                      de_modrm_pr,
  output logic                      de_sib_pr,
  output logic [1:0]                de_scale,
  output logic [31:0]               de_disp32,
  output logic [31:0]               de_imm32,
  output seg_t                      de_seg,
  output logic                      de_size_over,
  output logic                      de_repne
);

  logic [2:0]       pfx_count;
  logic             size_over;
  logic             repne;
  logic             seg_over_pr;
  seg_t             seg_over;
  logic [7:0]       opcode;
  logic [7:0]       modrm;
  logic [2:0]       sib_base;
  op_class_t        op_class;
  logic             modrm_pr;
  logic [2:0]       imm_bytes;
  logic [2:0]       modrm_bytes;
  logic             sib_pr;
  logic [2:0]       disp_bytes;
  logic [1:0]       scale;
  logic [31:0]      disp32;
  logic [31:0]      imm32;
  logic [LEN_W-1:0] len;
  logic [EIP_W-1:0] eip_next;

  prefix_scan #(.MAX_PREFIX(MAX_PREFIX)) u_prefix_scan (
    .fetch_bytes (fetch_bytes),
    .pfx_count   (pfx_count),
    .size_over   (size_over),
    .repne       (repne),
    .seg_over_pr (seg_over_pr),
    .seg_over    (seg_over)
  );

  opcode_table u_opcode_table (
    .opcode    (opcode),
    .size_over (size_over),
    .op_class  (op_class),
    .modrm_pr  (modrm_pr),
    .imm_bytes (imm_bytes)
  );

  modrm_decode u_modrm_decode (
    .modrm       (modrm),
    .sib_base    (sib_base),
    .modrm_bytes (modrm_bytes),
    .sib_pr      (sib_pr),
    .disp_bytes  (disp_bytes)
  );

  field_extract #(.MAX_PREFIX(MAX_PREFIX)) u_field_extract (
    .fetch_bytes (fetch_bytes),
    .fetch_eip   (fetch_eip),
    .pfx_count   (pfx_count),
    .size_over   (size_over),
    .op_class    (op_class),
    .modrm_pr    (modrm_pr),
    .imm_bytes   (imm_bytes),
    .modrm_bytes (modrm_bytes),
    .sib_pr      (sib_pr),
    .disp_bytes  (disp_bytes),
    .opcode      (opcode),
    .modrm       (modrm),
    .sib_base    (sib_base),
    .scale       (scale),
    .disp32      (disp32),
    .imm32       (imm32),
    .len         (len),
    .eip_next    (eip_next)
  );

  decode_latch u_decode_latch (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_valid  (fetch_valid),
    .eip_curr     (fetch_eip),
    .eip_next     (eip_next),
    .len          (len),
    .op_class     (op_class),
    .opcode       (opcode),
    .modrm_pr     (modrm_pr),
    .sib_pr       (sib_pr),
    .scale        (scale),
    .disp32       (disp32),
    .imm32        (imm32),
    .size_over    (size_over),
    .seg_over_pr  (seg_over_pr),
    .seg_over     (seg_over),
    .repne        (repne),
    .de_valid     (de_valid),
    .de_eip_curr  (de_eip_curr),
    .de_eip_next  (de_eip_next),
    .de_len       (de_len),
    .de_op_class  (de_op_class),
    .de_opcode    (de_opcode),
    .de_modrm_pr  (de_modrm_pr),
    .de_sib_pr    (de_sib_pr),
    .de_scale     (de_scale),
    .de_disp32    (de_disp32),
    .de_imm32     (de_imm32),
    .de_seg       (de_seg),
    .de_size_over (de_size_over),
    .de_repne     (de_repne)
  );

endmodule

/* tb_decode_stage.sv */
// **************************************************
// Decode stage testbench
// Replays instruction vectors from a data file and
// checks the registered decode outputs
// **************************************************

`timescale 1ns/1ns

module tb_decode_stage import decode_pkg::*; ();

  localparam int MAX_VEC     = 64;
  localparam int TIMEOUT_CYC = 10;
  localparam int MAX_PFX     = 4;

  logic                      clk;
  logic                      rst_n;
  logic                      fetch_valid;
  logic [EIP_W-1:0]          fetch_eip;
  logic [WINDOW_BYTES*8-1:0] fetch_bytes;
  logic                      de_valid;
  logic [EIP_W-1:0]          de_eip_curr;
  logic [EIP_W-1:0]          de_eip_next;
  logic [LEN_W-1:0]          de_len;
  op_class_t                 de_op_class;
  logic [7:0]                de_opcode;
  logic                      de_modrm_pr;
  logic                      de_sib_pr;
  logic [1:0]                de_scale;
  logic [31:0]               de_disp32;
  logic [31:0]               de_imm32;
  seg_t                      de_seg;
  logic                      de_size_over;
  logic                      de_repne;

  // Vector table, one entry per line of the data file
  logic [31:0]               v_eip   [MAX_VEC];
  logic [WINDOW_BYTES*8-1:0] v_win   [MAX_VEC];
  logic [31:0]               v_len   [MAX_VEC];
  logic [31:0]               v_next  [MAX_VEC];
  logic [31:0]               v_class [MAX_VEC];
  logic [31:0]               v_disp  [MAX_VEC];
  logic [31:0]               v_imm   [MAX_VEC];
  logic [31:0]               v_seg   [MAX_VEC];
  logic [31:0]               v_size  [MAX_VEC];
  logic [31:0]               v_rep   [MAX_VEC];
  logic [31:0]               v_sib   [MAX_VEC];
  logic [31:0]               v_scale [MAX_VEC];

  int num_vec;
  int errors;
  bit timed_out;
  int exp_q[$];

  decode_stage #(.MAX_PREFIX(MAX_PFX)) UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_valid  (fetch_valid),
    .fetch_eip    (fetch_eip),
    .fetch_bytes  (fetch_bytes),
    .de_valid     (de_valid),
    .de_eip_curr  (de_eip_curr),
    .de_eip_next  (de_eip_next),
    .de_len       (de_len),
    .de_op_class  (de_op_class),
    .de_opcode    (de_opcode),
    .de_modrm_pr  (de_modrm_pr),
    .de_sib_pr    (de_sib_pr),
    .de_scale     (de_scale),
    .de_disp32    (de_disp32),
    .de_imm32     (de_imm32),
    .de_seg       (de_seg),
    .de_size_over (de_size_over),
    .de_repne     (de_repne)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // repne, six segment overrides, operand size and 0F
  function automatic bit is_prefix_byte(input logic [7:0] b);
    case (b)
      8'hF2, 8'h2E, 8'h36, 8'h3E, 8'h26,
      8'h64, 8'h65, 8'h66, 8'h0F: return 1'b1;
      default:                    return 1'b0;
    endcase
  endfunction

  // Opcode sits right after the unbroken prefix run at the head
  function automatic logic [7:0] opcode_of(input logic [WINDOW_BYTES*8-1:0] win);
    int n;
    n = 0;
    while (n < MAX_PFX && is_prefix_byte(win[n*8 +: 8])) begin
      n++;
    end
    return win[n*8 +: 8];
  endfunction

  // Table entries that carry a ModRM byte
  function automatic logic has_modrm(input logic [7:0] op);
    return (op == 8'h01 || op == 8'h81 || op == 8'h83 || op == 8'h89 || op == 8'h8B);
  endfunction

  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("decode_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open decode_input.txt for reading");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#" && num_vec < MAX_VEC) begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        v_eip[num_vec], v_win[num_vec], v_len[num_vec],
                        v_next[num_vec], v_class[num_vec], v_disp[num_vec],
                        v_imm[num_vec], v_seg[num_vec], v_size[num_vec],
                        v_rep[num_vec], v_sib[num_vec], v_scale[num_vec]);
          if (cnt == 12) begin
            num_vec++;
          end else if (cnt > 0) begin
            $display("Malformed vector line skipped: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Back to back, one instruction per cycle
  task automatic drive_vectors();
    for (int i = 0; i < num_vec; i++) begin
      @(negedge clk);
      fetch_valid = 1'b1;
      fetch_eip   = v_eip[i];
      fetch_bytes = v_win[i];
      exp_q.push_back(i);
    end
    @(negedge clk);
    fetch_valid = 1'b0;
    fetch_eip   = 32'hFFFF_FFF0;
    fetch_bytes = '1;
  endtask

  task automatic wait_valid(output int waited, output bit ok);
    waited = 0;
    ok     = 1'b0;
    while (!ok && waited <= TIMEOUT_CYC) begin
      @(negedge clk);
      if (de_valid === 1'b1) begin
        ok = 1'b1;
      end else begin
        waited++;
      end
    end
  endtask

  task automatic check_outputs();
    int    idx;
    int    waited;
    bit    ok;
    string tag;
    for (int k = 0; k < num_vec; k++) begin
      wait_valid(waited, ok);
      if (!ok) begin
        $display("Timed out waiting for de_valid of vector %0d", k);
        errors++;
        timed_out = 1'b1;
        break;
      end
      if (exp_q.size() == 0) begin
        $display("de_valid pulse with no instruction outstanding");
        errors++;
        break;
      end
      // After the first result the pulses must follow cycle by cycle
      if (k > 0) begin
        assert (waited == 0) else begin
          errors++;
          $display("de_valid for vector %0d came %0d cycles late", k, waited);
        end
      end
      idx = exp_q.pop_front();
      tag = $sformatf("vector %0d", idx);
      check_val({tag, " eip_curr"}, v_eip[idx], de_eip_curr);
      check_val({tag, " len"}, v_len[idx], de_len);
      check_val({tag, " eip_next"}, v_next[idx], de_eip_next);
      check_val({tag, " op_class"}, v_class[idx], de_op_class);
      check_val({tag, " opcode"}, opcode_of(v_win[idx]), de_opcode);
      check_val({tag, " modrm_pr"}, has_modrm(opcode_of(v_win[idx])), de_modrm_pr);
      check_val({tag, " disp32"}, v_disp[idx], de_disp32);
      check_val({tag, " imm32"}, v_imm[idx], de_imm32);
      check_val({tag, " seg"}, v_seg[idx], de_seg);
      check_val({tag, " size_over"}, v_size[idx], de_size_over);
      check_val({tag, " repne"}, v_rep[idx], de_repne);
      check_val({tag, " sib_pr"}, v_sib[idx], de_sib_pr);
      check_val({tag, " scale"}, v_scale[idx], de_scale);
    end
  endtask

  // Fields keep the last instruction once the strobe drops
  task automatic check_hold();
    int waited;
    waited = 0;
    while (de_valid !== 1'b0 && waited < TIMEOUT_CYC) begin
      @(negedge clk);
      waited++;
    end
    if (de_valid !== 1'b0) begin
      $display("de_valid stayed high after the last instruction");
      errors++;
    end else begin
      repeat (2) @(negedge clk);
      check_val("hold de_valid", 32'd0, de_valid);
      check_val("hold de_len", v_len[num_vec-1], de_len);
      check_val("hold de_eip_curr", v_eip[num_vec-1], de_eip_curr);
    end
  endtask

  task automatic finish_run();
    $display("Vectors %0d, errors %0d", num_vec, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    fetch_eip   = '0;
    fetch_bytes = '0;
    errors      = 0;
    num_vec     = 0;
    timed_out   = 1'b0;
    load_vectors();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_val("reset de_valid", 32'd0, de_valid);
    check_val("reset de_len", 32'd0, de_len);
    if (num_vec == 0) begin
      $display("No vectors were loaded");
      errors++;
    end else begin
      fork
        drive_vectors();
        check_outputs();
      join
      if (!timed_out) begin
        check_hold();
      end
    end
    finish_run();
  end

endmodule

/* decode_input.txt */
# eip window(byte15..byte0) len eip_next class disp imm seg size_over repne sib_pr scale
# class 0 nop 1 alu 2 mov 3 branch 4 hlt 5 iret 6 invalid, seg 0 es 1 cs 2 ss 3 ds 4 fs 5 gs
00001000 00000000000000000000000000000090 1 00001001 0 00000000 00000000 3 0 0 0 0
00001001 000000000000000000000000000000F4 1 00001002 4 00000000 00000000 3 0 0 0 0
00001002 000000000000000000000000000000CF 1 00001003 5 00000000 00000000 3 0 0 0 0
00001003 000000000000000000000012345678E8 5 00001008 3 00000000 12345678 3 0 0 0 0
00001008 0000000000000000000000000000F0EB 2 0000100A 3 00000000 FFFFFFF0 3 0 0 0 0
0000100A 0000000000000000000000DEADBEEFB8 5 0000100F 2 00000000 DEADBEEF 3 0 0 0 0
0000100F 0000000000000000000000000000C801 2 00001011 1 00000000 00000000 3 0 0 0 0
00001011 00000000000000000000112233440589 6 00001017 2 11223344 00000000 3 0 0 0 0
00001017 00000000000000000000000000FC458B 3 0000101A 2 FFFFFFFC 00000000 3 0 0 0 0
0000101A 00000000000000007F000010008D0483 8 00001022 1 00001000 0000007F 3 0 0 1 2
00001022 00000000000000000000001234C08166 5 00001027 1 00000000 00001234 3 1 0 0 0
00001027 000000000000000000000000ABCDB866 4 0000102B 2 00000000 0000ABCD 3 1 0 0 0
0000102B 0000000000000000000000008000E866 4 0000102F 3 00000000 00008000 3 1 0 0 0
0000102F 000000000000000000000000000090F2 2 00001031 0 00000000 00000000 3 0 1 0 0
00001031 0000000000000000001234E86566F23E 7 00001038 3 00000000 00001234 5 1 1 0 0
00001038 00000000000000000000000000006690 1 00001039 0 00000000 00000000 3 0 0 0 0
00001039 00000000000000000000000000008B64 3 0000103C 2 00000000 00000000 4 0 0 0 0
0000103C 000000000000000000000000C389362E 4 00001040 2 00000000 00000000 2 0 0 0 0
00001040 0000000000000000000000002444C766 2 00001042 6 00000000 00000000 3 1 0 0 0
00001042 000000000000000000000000000000D6 1 00001043 6 00000000 00000000 3 0 0 0 0

/* filelist.f */
decode_pkg.sv
prefix_scan.sv
opcode_table.sv
modrm_decode.sv
field_extract.sv
decode_latch.sv
decode_stage.sv
tb_decode_stage.sv
